/* Makefile */
# Verilator build and run of the retirement path testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run tb_retire and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -f project.f --top-module tb_retire -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* dv/retire_model.svh */
/* Cycle model of the retirement path, included inside the testbench module.
   Reads the testbench input signals directly. Writebacks must name live entries not yet ready. */
`ifndef RETIRE_MODEL_SVH
`define RETIRE_MODEL_SVH

// Live entries, oldest at index 0
rob_pkg::rob_entry_t m_rob[$];
rob_pkg::word_t      m_regs[`NUM_REGS];
rob_pkg::rob_tag_t   m_tail;
rob_pkg::reg_idx_t   m_wrote_rd;
rob_pkg::word_t      exp_redirect_pc;
logic                m_wrote;
logic                exp_redirect_valid;
int                  branches_retired;

function automatic void model_reset();
    m_rob.delete();
    foreach (m_regs[i]) begin
        m_regs[i] = '0;
    end
    m_tail             = '0;
    m_wrote            = 1'b0;
    exp_redirect_valid = 1'b0;
    branches_retired   = 0;
endfunction

// Broadcast seen while the head sits in the buffer
function automatic rob_pkg::cdb_packet_t expected_packet();
    rob_pkg::cdb_packet_t pkt;
    rob_pkg::rob_entry_t  h;
    pkt = '0;
    if (m_rob.size() > 0) begin
        h = m_rob[0];
        // Top bit of the class marks a register write
        if (h.ready && h.itype[1]) begin
            pkt.tag    = h.tag;
            pkt.result = h.value;
        end
    end
    return pkt;
endfunction

// One rising edge, using the inputs held just before it
function automatic void model_edge();
    rob_pkg::rob_entry_t h;
    rob_pkg::rob_entry_t e;
    logic                was_full;
    logic                retiring;
    logic                mispredict;
    was_full   = (m_rob.size() == `ROB_DEPTH);
    retiring   = 1'b0;
    mispredict = 1'b0;
    m_wrote    = 1'b0;
    h          = '0;
    if (m_rob.size() > 0 && m_rob[0].ready) begin
        h = m_rob[0];
        case (h.itype)
            rob_pkg::ITYPE_BRANCH: begin
                retiring   = 1'b1;
                mispredict = (h.branch_pred != h.branch_result);
                branches_retired++;
            end
            rob_pkg::ITYPE_STORE: retiring = store_done;
            default: begin
                retiring   = 1'b1;
                m_wrote    = 1'b1;
                m_wrote_rd = h.rd;
                if (h.rd != '0) begin
                    m_regs[h.rd] = h.value;
                end
            end
        endcase
    end
    exp_redirect_valid = mispredict;
    if (mispredict) begin
        exp_redirect_pc = h.branch_result ? h.pc + h.value : h.pc + `PC_STEP;
    end
    if (wb_valid) begin
        foreach (m_rob[i]) begin
            if (m_rob[i].tag == wb_packet.tag) begin
                e               = m_rob[i];
                e.ready         = 1'b1;
                e.branch_result = wb_packet.branch_result;
                // Branch keeps its immediate
                if (e.itype != rob_pkg::ITYPE_BRANCH) begin
                    e.value = wb_packet.result;
                end
                m_rob[i] = e;
            end
        end
    end
    // Wrong path: younger entries and this edge's dispatch are lost
    if (mispredict) begin
        m_rob.delete();
        m_tail = '0;
    end else begin
        if (retiring) begin
            void'(m_rob.pop_front());
        end
        if (alloc_valid && !was_full) begin
            e             = '0;
            e.itype       = alloc_entry.itype;
            e.rd          = alloc_entry.rd;
            e.pc          = alloc_entry.pc;
            e.value       = alloc_entry.value;
            e.branch_pred = alloc_pred;
            e.tag         = m_tail;
            m_rob.push_back(e);
            m_tail = m_tail + 1'b1;
        end
    end
endfunction

`endif

/* dv/tb_retire.sv */
/* Random testbench for retire_top, compared every cycle with a cycle model, seed 42.
   Inputs change on rising edges and outputs are compared on falling edges. */
`timescale 1ns/1ps
`include "rob_consts.svh"

module tb_retire;

    localparam int CLK_PERIOD = 20;
    localparam int DRAIN_MAX  = 48;
    localparam int LEN_SWEEP  = `NUM_REGS / 2;
    localparam int LEN_RANDOM = 300;
    localparam int LEN_BLOCK  = 30;
    localparam int LEN_RESUME = 150;
    localparam int LEN_BRANCH = 200;
    localparam int LEN_ZERO   = 100;
    // All tests and drains, then a margin
    localparam int WATCHDOG_CYCLES = 2 + LEN_SWEEP + LEN_RANDOM + LEN_BLOCK + LEN_RESUME
                                     + 2 * LEN_BRANCH + LEN_ZERO + 4 * DRAIN_MAX + 100;

    logic                 clk, reset, full, store_done;
    logic                 alloc_valid, alloc_pred, wb_valid, redirect_valid;
    rob_pkg::dispatch_t   alloc_entry;
    rob_pkg::rob_tag_t    alloc_tag;
    rob_pkg::cdb_packet_t wb_packet, commit_packet;
    rob_pkg::reg_idx_t    rs1, rs2;
    rob_pkg::word_t       rs1_data, rs2_data, redirect_pc;

    // mix 0 ALU and load, 1 adds stores, 2 any class, 3 ALU only
    // branch_mode 0 random, 1 always wrong, 2 always right; done_mode 0 low, 1 high, 2 random
    int    p_dispatch, p_wb, mix, branch_mode, done_mode, p_rd_zero, sweep;
    logic  force_store;
    int    seed, test_errors, tests_passed, tests_failed, redirects_seen;
    string test_name;

    `include "retire_model.svh"

    retire_top retire_top_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic compare_value(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_outputs();
        compare_value("commit_packet", 64'(expected_packet()), 64'(commit_packet));
        compare_value("full", 64'(m_rob.size() == `ROB_DEPTH), 64'(full));
        compare_value("alloc_tag", 64'(m_tail), 64'(alloc_tag));
        compare_value("redirect_valid", 64'(exp_redirect_valid), 64'(redirect_valid));
        if (exp_redirect_valid) begin
            compare_value("redirect_pc", 64'(exp_redirect_pc), 64'(redirect_pc));
        end
        if (redirect_valid) begin
            redirects_seen++;
        end
        compare_value("rs1_data", 64'(m_regs[rs1]), 64'(rs1_data));
        compare_value("rs2_data", 64'(m_regs[rs2]), 64'(rs2_data));
    endtask

    task automatic pick_inputs();
        int                   open_idx[$];
        rob_pkg::dispatch_t   d;
        rob_pkg::cdb_packet_t w;
        rob_pkg::rob_entry_t  e;
        logic                 do_alloc;
        d        = '0;
        w        = '0;
        do_alloc = force_store || (rand_below(100) < p_dispatch);
        case (mix)
            0: d.itype = rand_below(2) ? rob_pkg::ITYPE_ALU : rob_pkg::ITYPE_LOAD;
            1: d.itype = rob_pkg::itype_t'(2'(1 + rand_below(3)));
            2: d.itype = rob_pkg::itype_t'(2'(rand_below(4)));
            default: d.itype = rob_pkg::ITYPE_ALU;
        endcase
        if (force_store) begin
            d.itype     = rob_pkg::ITYPE_STORE;
            force_store = 1'b0;
        end
        d.rd = (rand_below(100) < p_rd_zero) ? '0 : rob_pkg::reg_idx_t'(rand_below(`NUM_REGS));
        d.pc = rob_pkg::word_t'($random(seed)) & 32'hFFFF_FFFC;
        if (d.itype == rob_pkg::ITYPE_BRANCH) begin
            d.value = rob_pkg::word_t'(rand_below(4096) - 2048) & 32'hFFFF_FFFE;
        end else begin
            d.value = rob_pkg::word_t'($random(seed));
        end
        alloc_valid <= do_alloc;
        alloc_entry <= d;
        alloc_pred  <= 1'(rand_below(2));
        // Writeback goes to a random entry still waiting
        foreach (m_rob[i]) begin
            if (!m_rob[i].ready) begin
                open_idx.push_back(i);
            end
        end
        wb_valid <= 1'b0;
        if (open_idx.size() > 0 && rand_below(100) < p_wb) begin
            e        = m_rob[open_idx[rand_below(open_idx.size())]];
            w.tag    = e.tag;
            w.result = rob_pkg::word_t'($random(seed));
            case (branch_mode)
                1: w.branch_result = !e.branch_pred;
                2: w.branch_result = e.branch_pred;
                default: w.branch_result = 1'(rand_below(2));
            endcase
            wb_valid <= 1'b1;
        end
        wb_packet  <= w;
        store_done <= (done_mode == 2) ? 1'(rand_below(2)) : (done_mode == 1);
        if (sweep >= 0) begin
            rs1   <= rob_pkg::reg_idx_t'(2 * sweep);
            rs2   <= rob_pkg::reg_idx_t'(2 * sweep + 1);
            sweep++;
        end else begin
            rs1 <= m_wrote ? m_wrote_rd : rob_pkg::reg_idx_t'(rand_below(`NUM_REGS));
            rs2 <= rob_pkg::reg_idx_t'(rand_below(`NUM_REGS));
        end
    endtask

    task automatic tick();
        @(posedge clk);
        model_edge();
        pick_inputs();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic set_knobs(input int dispatch_pct, input int wb_pct, input int mix_sel,
                             input int br_mode, input int done_sel, input int zero_pct);
        p_dispatch  = dispatch_pct;
        p_wb        = wb_pct;
        mix         = mix_sel;
        branch_mode = br_mode;
        done_mode   = done_sel;
        p_rd_zero   = zero_pct;
    endtask

    task automatic start_test(input string name);
        test_name        = name;
        test_errors      = 0;
        redirects_seen   = 0;
        branches_retired = 0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        set_knobs(0, 100, 0, 0, 1, 0);
        while (m_rob.size() > 0 && n < DRAIN_MAX) begin
            tick();
            n++;
        end
        if (m_rob.size() > 0) begin
            $display("%s: reorder buffer did not drain in %0d cycles", test_name, DRAIN_MAX);
            test_errors++;
        end
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("Test %s finished with %0d errors", test_name, test_errors);
    endtask

    initial begin
        seed        = 42;
        clk         = 1'b0;
        reset       = 1'b1;
        alloc_valid = 1'b0;
        alloc_entry = '0;
        alloc_pred  = 1'b0;
        wb_valid    = 1'b0;
        wb_packet   = '0;
        store_done  = 1'b0;
        rs1         = '0;
        rs2         = '0;
        sweep       = -1;
        force_store = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        model_reset();
        set_knobs(0, 0, 0, 0, 0, 0);
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        start_test("reset_state");
        sweep = 0;
        repeat (LEN_SWEEP) tick();
        sweep = -1;
        end_test();

        start_test("in_order_alu_load");
        set_knobs(60, 70, 0, 0, 1, 0);
        repeat (LEN_RANDOM) tick();
        end_test();

        start_test("store_backpressure");
        drain();
        set_knobs(100, 70, 0, 0, 0, 0);
        force_store = 1'b1;
        repeat (LEN_BLOCK) tick();
        if (!full) begin
            $display("%s: full stayed low while a store held the head", test_name);
            test_errors++;
        end
        set_knobs(60, 70, 1, 0, 2, 0);
        repeat (LEN_RESUME) tick();
        end_test();

        start_test("branch_mispredict");
        drain();
        set_knobs(60, 70, 2, 1, 1, 0);
        repeat (LEN_BRANCH) tick();
        if (redirects_seen == 0) begin
            $display("%s: no redirect was seen for any mispredicted branch", test_name);
            test_errors++;
        end
        end_test();

        start_test("branch_correct");
        drain();
        set_knobs(60, 70, 2, 2, 1, 0);
        repeat (LEN_BRANCH) tick();
        if (branches_retired == 0) begin
            $display("%s: no branch retired during the test", test_name);
            test_errors++;
        end
        end_test();

        start_test("write_x0");
        drain();
        set_knobs(60, 70, 3, 0, 1, 50);
        repeat (LEN_ZERO) tick();
        end_test();

        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* include/rob_consts.svh */
/* Sizing constants for the retirement path.
   ROB_DEPTH must be a power of two equal to 2**ROB_TAG_W. */
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// Reorder buffer
`define ROB_DEPTH 16
`define ROB_TAG_W 4

// Architectural state
`define NUM_REGS 32
`define XLEN 32

// Fall-through distance for a not-taken branch
`define PC_STEP 4

`endif

/* project.f */
+incdir+include
+incdir+dv
src/rob_pkg.sv
src/rob_queue.sv
src/commit.sv
src/arch_regfile.sv
src/branch_redirect.sv
src/retire_top.sv
dv/tb_retire.sv

/* src/arch_regfile.sv */
/* Architectural register file, one write port and two combinational read ports.
   Register zero is never written and always reads zero. New values are visible after the edge. */
`timescale 1ns/1ps
`include "rob_consts.svh"

module arch_regfile (
    input  logic             clk,
    input  logic             reset,
    input  rob_pkg::commit_t retire,
    input  rob_pkg::reg_idx_t rs1,
    input  rob_pkg::reg_idx_t rs2,
    output rob_pkg::word_t   rs1_data,
    output rob_pkg::word_t   rs2_data
);

    rob_pkg::word_t regs [`NUM_REGS];
    logic           write_en;

    // Writes aimed at x0 are dropped
    assign write_en = retire.reg_write && (retire.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[retire.rd] <= retire.write_data;
        end
    end

    // Register zero keeps its reset value
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

/* src/branch_redirect.sv */
/* Mispredict check for a retiring branch.
   flush is combinational in the retire cycle, redirect is a one-cycle pulse the cycle after. */
`timescale 1ns/1ps
`include "rob_consts.svh"

module branch_redirect (
    input  logic           clk,
    input  logic           reset,
    input  logic           br_commit,
    input  logic           br_pred,
    input  logic           br_result,
    input  rob_pkg::word_t br_pc,
    input  rob_pkg::word_t br_imm,
    output logic           flush,
    output logic           redirect_valid,
    output rob_pkg::word_t redirect_pc
);

    logic           mispredict;
    rob_pkg::word_t target;

    assign mispredict = br_commit && (br_pred != br_result);

    // Younger entries are all on the wrong path
    assign flush = mispredict;

    // Taken goes to pc + imm, not taken falls through
    assign target = br_result ? (br_pc + br_imm)
                              : (br_pc + rob_pkg::word_t'(`PC_STEP));

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= mispredict;
        end
    end

    // Target only captured on a mispredict
    always_ff @(posedge clk) begin
        if (mispredict) begin
            redirect_pc <= target;
        end
    end

endmodule

/* src/commit.sv */
/* Zero-cycle retirement decision for the ROB head, one instruction per cycle.
   A store retires only while store_done is high. Outputs are zero when nothing retires. */
`timescale 1ns/1ps

module commit (
    input  rob_pkg::rob_entry_t  head,
    input  logic                 empty,
    input  logic                 store_done,
    output logic                 deq,
    output rob_pkg::commit_t     retire,
    output logic                 br_commit,
    output logic                 br_pred,
    output logic                 br_result,
    output rob_pkg::word_t       br_pc,
    output rob_pkg::word_t       br_imm,
    output rob_pkg::cdb_packet_t commit_packet
);

    logic head_valid;

    assign head_valid = head.ready && !empty;

    always_comb begin
        deq       = 1'b0;
        retire    = '0;
        br_commit = 1'b0;
        br_pred   = 1'b0;
        br_result = 1'b0;
        br_pc     = '0;
        br_imm    = '0;

        if (head_valid) begin
            case (head.itype)
                rob_pkg::ITYPE_BRANCH: begin
                    // Hand the outcome to the redirect logic
                    deq       = 1'b1;
                    br_commit = 1'b1;
                    br_pred   = head.branch_pred;
                    br_result = head.branch_result;
                    br_pc     = head.pc;
                    br_imm    = head.value;
                end
                rob_pkg::ITYPE_STORE: begin
                    // Held at the head until memory reports completion
                    deq = store_done;
                end
                default: begin
                    // Load and ALU write their destination
                    deq               = 1'b1;
                    retire.reg_write  = 1'b1;
                    retire.rd         = head.rd;
                    retire.write_data = head.value;
                end
            endcase
        end

        if (deq) begin
            retire.tag = head.tag;
        end
    end

    // Broadcast only register-writing retirements
    always_comb begin
        commit_packet = '0;
        if (retire.reg_write) begin
            commit_packet.tag    = retire.tag;
            commit_packet.result = retire.write_data;
        end
    end

endmodule

/* src/retire_top.sv */
/* Retirement path: ROB, commit, architectural registers and branch redirect.
   Dispatch, writeback and store_done are plain strobes with no handshake. */
`timescale 1ns/1ps

module retire_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 alloc_valid,
    input  rob_pkg::dispatch_t   alloc_entry,
    input  logic                 alloc_pred,
    output rob_pkg::rob_tag_t    alloc_tag,
    output logic                 full,
    input  logic                 wb_valid,
    input  rob_pkg::cdb_packet_t wb_packet,
    input  logic                 store_done,
    input  rob_pkg::reg_idx_t    rs1,
    input  rob_pkg::reg_idx_t    rs2,
    output rob_pkg::word_t       rs1_data,
    output rob_pkg::word_t       rs2_data,
    output rob_pkg::cdb_packet_t commit_packet,
    output logic                 redirect_valid,
    output rob_pkg::word_t       redirect_pc
);

    rob_pkg::rob_entry_t head;
    logic                empty;
    logic                deq;
    logic                flush;
    rob_pkg::commit_t    retire;
    logic                br_commit;
    logic                br_pred;
    logic                br_result;
    rob_pkg::word_t      br_pc;
    rob_pkg::word_t      br_imm;

    rob_queue rob_queue_i (
        .clk         (clk),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .alloc_entry (alloc_entry),
        .alloc_pred  (alloc_pred),
        .alloc_tag   (alloc_tag),
        .full        (full),
        .wb_valid    (wb_valid),
        .wb_packet   (wb_packet),
        .head        (head),
        .empty       (empty),
        .deq         (deq),
        .flush       (flush)
    );

    commit commit_i (
        .head          (head),
        .empty         (empty),
        .store_done    (store_done),
        .deq           (deq),
        .retire        (retire),
        .br_commit     (br_commit),
        .br_pred       (br_pred),
        .br_result     (br_result),
        .br_pc         (br_pc),
        .br_imm        (br_imm),
        .commit_packet (commit_packet)
    );

    arch_regfile arch_regfile_i (
        .clk      (clk),
        .reset    (reset),
        .retire   (retire),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    branch_redirect branch_redirect_i (
        .clk            (clk),
        .reset          (reset),
        .br_commit      (br_commit),
        .br_pred        (br_pred),
        .br_result      (br_result),
        .br_pc          (br_pc),
        .br_imm         (br_imm),
        .flush          (flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* src/rob_pkg.sv */
/* Shared types for the ROB, commit and redirect blocks.
   Widths come from rob_consts.svh. An itype_t with its top bit set writes a register. */
`include "rob_consts.svh"

package rob_pkg;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;
    typedef logic [`XLEN-1:0] word_t;

    typedef enum logic [1:0] {
        ITYPE_BRANCH = 2'd0,
        ITYPE_STORE  = 2'd1,
        ITYPE_LOAD   = 2'd2,
        ITYPE_ALU    = 2'd3
    } itype_t;

    // Dispatched instruction, value holds the branch immediate
    typedef struct packed {
        itype_t   itype;
        reg_idx_t rd;
        word_t    pc;
        word_t    value;
    } dispatch_t;

    // One reorder buffer slot
    typedef struct packed {
        itype_t   itype;
        logic     ready;
        reg_idx_t rd;
        word_t    pc;
        word_t    value;
        logic     branch_pred;
        logic     branch_result;
        rob_tag_t tag;
    } rob_entry_t;

    // Writeback in, commit broadcast out
    typedef struct packed {
        rob_tag_t tag;
        word_t    result;
        logic     branch_result;
    } cdb_packet_t;

    // Register file side of a retirement
    typedef struct packed {
        logic     reg_write;
        reg_idx_t rd;
        word_t    write_data;
        rob_tag_t tag;
    } commit_t;

endpackage

/* src/rob_queue.sv */
/* Circular reorder buffer, one allocate and one dequeue per cycle.
   Writeback tags must name allocated slots. Flush empties the buffer and blocks allocation. */
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_queue (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 alloc_valid,
    input  rob_pkg::dispatch_t   alloc_entry,
    input  logic                 alloc_pred,
    output rob_pkg::rob_tag_t    alloc_tag,
    output logic                 full,
    input  logic                 wb_valid,
    input  rob_pkg::cdb_packet_t wb_packet,
    output rob_pkg::rob_entry_t  head,
    output logic                 empty,
    input  logic                 deq,
    input  logic                 flush
);

    localparam int COUNT_W = $clog2(`ROB_DEPTH + 1);

    rob_pkg::rob_entry_t entries [`ROB_DEPTH];
    rob_pkg::rob_tag_t   head_ptr;
    rob_pkg::rob_tag_t   tail_ptr;
    logic [COUNT_W-1:0]  count;
    logic                do_alloc;
    logic                do_deq;
    rob_pkg::rob_entry_t new_entry;

    // Slot index wraps through the tag width
    function automatic rob_pkg::rob_tag_t next_ptr(input rob_pkg::rob_tag_t ptr);
        return ptr + 1'b1;
    endfunction

    assign full  = (count == COUNT_W'(`ROB_DEPTH));
    assign empty = (count == '0);

    // Flush wins over a dispatch in the same cycle
    assign do_alloc = alloc_valid && !full && !flush;
    assign do_deq   = deq && !empty;

    // New tag is known before the edge that stores the entry
    assign alloc_tag = tail_ptr;

    always_comb begin
        new_entry               = '0;
        new_entry.itype         = alloc_entry.itype;
        new_entry.ready         = 1'b0;
        new_entry.rd            = alloc_entry.rd;
        new_entry.pc            = alloc_entry.pc;
        new_entry.value         = alloc_entry.value;
        new_entry.branch_pred   = alloc_pred;
        new_entry.branch_result = 1'b0;
        new_entry.tag           = tail_ptr;
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_alloc) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (do_deq) begin
                head_ptr <= next_ptr(head_ptr);
            end
            case ({do_alloc, do_deq})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Slot contents
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            entries[wb_packet.tag].ready         <= 1'b1;
            entries[wb_packet.tag].branch_result <= wb_packet.branch_result;
            // Branch keeps its immediate for the redirect target
            if (entries[wb_packet.tag].itype != rob_pkg::ITYPE_BRANCH) begin
                entries[wb_packet.tag].value <= wb_packet.result;
            end
        end
        // Fresh allocation overrides any stale writeback to the same slot
        if (do_alloc) begin
            entries[tail_ptr] <= new_entry;
        end
    end

    assign head = entries[head_ptr];

endmodule
